// File: project.f
+incdir+.
xv_pkg.sv
xv_ifs.sv
vram_bank.sv
vram.sv
vram_arbiter.sv
host_regs.sv
line_scanner.sv
xv_top.sv
tb_xv_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_xv_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_xv_top.sv
/*
 * Testbench for the video memory subsystem.
 * Host register strobes and scans use random addresses and data,
 * every returned word is checked against a 64K-word model.
 */

`timescale 1ns/1ps

module tb_xv_top;

    localparam int WAIT_LIMIT = 2000;   // wait limit in cycles above a full 511-word scan

    logic             clk;
    logic             rst;
    logic             reg_wr;
    logic             reg_rd;
    xv_pkg::reg_num_t reg_num;
    logic [15:0]      reg_wdata;
    logic [15:0]      reg_rdata;
    logic             busy;
    logic             scan_start;
    logic [15:0]      scan_base;
    logic [8:0]       scan_len;
    logic [15:0]      scan_data;
    logic             scan_valid;
    logic             scan_busy;

    logic [15:0] model [0:65535];
    logic [15:0] wa;            // expected write address
    logic [15:0] ra;            // expected read address
    logic [15:0] pref_word;     // word the prefetch must hold
    logic [15:0] exp_q [$];
    logic [15:0] got_q [$];
    integer      seed;

    xv_top dut_i (
        .clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_num(reg_num),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .busy(busy),
        .scan_start(scan_start), .scan_base(scan_base), .scan_len(scan_len),
        .scan_data(scan_data), .scan_valid(scan_valid), .scan_busy(scan_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // collect the scan stream mid-cycle
    always @(negedge clk) begin
        if (scan_valid === 1'b1) begin
            check("scan_busy with scan_valid", 16'(scan_busy), 16'h1);
            got_q.push_back(scan_data);
        end
    end

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [15:0] actual, input logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_host_idle();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            if (cycles >= WAIT_LIMIT) abort_run("timeout: host busy never fell");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_scan_idle();
        int cycles;
        cycles = 0;
        while (scan_busy !== 1'b0) begin
            if (cycles >= WAIT_LIMIT) abort_run("timeout: scan_busy never fell");
            @(negedge clk);
            cycles++;
        end
    endtask

    // one register write strobe issued on a falling edge
    task automatic strobe_write(input xv_pkg::reg_num_t num, input logic [15:0] data);
        reg_num   = num;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(negedge clk);
        reg_wr    = 1'b0;
        wait_host_idle();
    endtask

    task automatic check_reg(input xv_pkg::reg_num_t num, input logic [15:0] expected,
                             input string name);
        reg_num = num;
        @(negedge clk);
        check(name, reg_rdata, expected);
    endtask

    task automatic set_wr_addr(input logic [15:0] a);
        strobe_write(xv_pkg::REG_WR_ADDR, a);
        wa = a;
    endtask

    task automatic write_word(input logic [15:0] d);
        strobe_write(xv_pkg::REG_WR_DATA, d);
        model[wa] = d;
        wa = wa + 16'd1;
    endtask

    task automatic set_rd_addr(input logic [15:0] a);
        strobe_write(xv_pkg::REG_RD_ADDR, a);
        ra = a;
        pref_word = model[a];
    endtask

    task automatic read_word();
        check_reg(xv_pkg::REG_RD_DATA, pref_word, "reg_rdata");
        reg_rd = 1'b1;
        @(negedge clk);
        reg_rd = 1'b0;
        ra = ra + 16'd1;
        pref_word = model[ra];          // next word is fetched now
        wait_host_idle();
    endtask

    task automatic burst_check(input logic [15:0] start, input int n);
        set_wr_addr(start);
        for (int i = 0; i < n; i++) write_word(rand16());
        check_reg(xv_pkg::REG_WR_ADDR, start + 16'(n), "write address");
        set_rd_addr(start);
        for (int i = 0; i < n; i++) read_word();
        check_reg(xv_pkg::REG_RD_ADDR, start + 16'(n), "read address");
    endtask

    task automatic start_scan(input logic [15:0] base, input logic [8:0] len);
        exp_q.delete();
        got_q.delete();
        for (int i = 0; i < int'(len); i++) exp_q.push_back(model[base + 16'(i)]);
        scan_base  = base;
        scan_len   = len;
        scan_start = 1'b1;
        @(negedge clk);
        scan_start = 1'b0;
    endtask

    task automatic finish_scan();
        wait_scan_idle();
        check("scan word count", 16'(got_q.size()), 16'(exp_q.size()));
        foreach (exp_q[i]) check("scan_data", got_q[i], exp_q[i]);
    endtask

    initial begin
        logic [15:0] base;
        logic [15:0] r;
        seed = 32'h704f8cf3;
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_num = xv_pkg::REG_WR_ADDR;
        reg_wdata = '0;
        scan_start = 1'b0;
        scan_base = '0;
        scan_len = '0;
        wa = '0;
        ra = '0;
        pref_word = 16'hdead;
        for (int i = 0; i < 65536; i++) model[i] = 16'hdead;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check("busy", 16'(busy), 16'h0);
        check("scan_busy", 16'(scan_busy), 16'h0);
        check("scan_valid", 16'(scan_valid), 16'h0);
        check("reg_rdata (write address)", reg_rdata, 16'h0);

        // nothing written yet so every word reads as the fill marker
        set_rd_addr(rand16());
        repeat (8) read_word();

        repeat (10) begin
            r = rand16();
            burst_check(rand16(), 1 + int'(r[3:0]));
        end
        burst_check(16'h3ffc, 8);      // bank 0 to 1
        burst_check(16'hbffc, 8);      // bank 2 to 3
        burst_check(16'hfffc, 8);      // wrap to 0

        for (int k = 0; k < 6; k++) begin
            base = rand16();
            set_wr_addr(base);
            repeat (12) write_word(rand16());
            r = rand16();
            start_scan(base, (k == 0) ? 9'd0 : (k == 1) ? 9'd1 : 9'(r[5:0]));
            finish_scan();
        end
        start_scan(16'hbf00, 9'd300);   // long run across a bank edge
        finish_scan();

        // host traffic kept half the address space away from the scan
        repeat (4) begin
            base = rand16();
            r = rand16();
            start_scan(base, 9'(64 + int'(r[6:0])));
            set_wr_addr(base ^ 16'h8000);
            repeat (4) write_word(rand16());
            set_rd_addr(base ^ 16'h8000);
            repeat (4) read_word();
            finish_scan();
        end

        repeat (400) begin
            r = rand16();
            case (r % 16'd5)
                16'd0: set_wr_addr(rand16());
                16'd1: begin
                    write_word(rand16());
                    check_reg(xv_pkg::REG_WR_ADDR, wa, "write address");
                end
                16'd2: set_rd_addr(rand16());
                16'd3: read_word();
                default: begin
                    start_scan(rand16(), 9'(r[8:4]));
                    finish_scan();
                end
            endcase
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: xv_top.sv
/*
 * Top level of the video memory subsystem.
 * Host registers and line scanner share the VRAM through the
 * arbiter, scanner first. Only instances and wiring live here.
 */

`timescale 1ns/1ps

module xv_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  xv_pkg::reg_num_t        reg_num,
    input  xv_pkg::vram_word_t      reg_wdata,
    output xv_pkg::vram_word_t      reg_rdata,
    output logic                    busy,
    input  logic                    scan_start,
    input  xv_pkg::vram_addr_t      scan_base,
    input  logic [8:0]              scan_len,
    output xv_pkg::vram_word_t      scan_data,
    output logic                    scan_valid,
    output logic                    scan_busy
);

    mem_req_if host_bus ();
    mem_req_if scan_bus ();
    vram_if    vram_bus ();

    host_regs host_regs_i (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_num   (reg_num),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .busy      (busy),
        .req       (host_bus.requester)
    );

    line_scanner line_scanner_i (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .scan_base  (scan_base),
        .scan_len   (scan_len),
        .scan_data  (scan_data),
        .scan_valid (scan_valid),
        .scan_busy  (scan_busy),
        .req        (scan_bus.requester)
    );

    vram_arbiter vram_arbiter_i (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_bus.arbiter),
        .host (host_bus.arbiter),
        .mem  (vram_bus.ctrl)
    );

    vram vram_i (
        .clk (clk),
        .mem (vram_bus.mem)
    );

endmodule

// File: line_scanner.sv
/*
 * Line scanner for the display side.
 * scan_start latches a base address and a word count, then one read
 * is issued per cycle; returned words stream out with scan_valid.
 * scan_busy falls the cycle after the last word.
 */

`timescale 1ns/1ps

module line_scanner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    scan_start,
    input  xv_pkg::vram_addr_t      scan_base,
    input  logic [8:0]              scan_len,
    output xv_pkg::vram_word_t      scan_data,
    output logic                    scan_valid,
    output logic                    scan_busy,
    mem_req_if.requester            req
);

    xv_pkg::scan_state_t state;
    xv_pkg::vram_addr_t  addr;
    logic [8:0]          issue_left;    // requests still to send
    logic [8:0]          recv_left;     // words still to arrive

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= xv_pkg::SC_IDLE;
            addr       <= '0;
            issue_left <= '0;
            recv_left  <= '0;
        end else begin
            if (req.rvalid) begin
                recv_left <= recv_left - 1'b1;
            end
            case (state)
                xv_pkg::SC_IDLE: begin
                    if (scan_start) begin
                        addr       <= scan_base;
                        issue_left <= scan_len;
                        recv_left  <= scan_len;
                        state      <= (scan_len == '0) ? xv_pkg::SC_DRAIN : xv_pkg::SC_FETCH;
                    end
                end
                xv_pkg::SC_FETCH: begin
                    if (req.gnt) begin
                        addr       <= addr + 1'b1;
                        issue_left <= issue_left - 1'b1;
                        if (issue_left == 9'd1) begin
                            state <= xv_pkg::SC_DRAIN;
                        end
                    end
                end
                xv_pkg::SC_DRAIN: begin
                    // last word arriving now, or nothing was fetched
                    if (recv_left == '0 || (req.rvalid && recv_left == 9'd1)) begin
                        state <= xv_pkg::SC_IDLE;
                    end
                end
                default: state <= xv_pkg::SC_IDLE;
            endcase
        end
    end

    assign req.req   = (state == xv_pkg::SC_FETCH);
    assign req.wr_en = 1'b0;            // read only
    assign req.addr  = addr;
    assign req.wdata = '0;

    assign scan_data  = req.rdata;
    assign scan_valid = req.rvalid;
    assign scan_busy  = (state != xv_pkg::SC_IDLE);

endmodule

// File: host_regs.sv
/*
 * Host register file for VRAM access.
 * Register 0/2 hold write/read address, 1 writes data (write address
 * auto-increments), 3 returns a prefetched word and fetches the next.
 * busy is high while the VRAM access of a strobe is outstanding and
 * the host must not strobe again until it falls.
 */

`timescale 1ns/1ps

module host_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  xv_pkg::reg_num_t        reg_num,
    input  xv_pkg::vram_word_t      reg_wdata,
    output xv_pkg::vram_word_t      reg_rdata,
    output logic                    busy,
    mem_req_if.requester            req
);

    xv_pkg::host_state_t state;
    xv_pkg::vram_addr_t  wr_addr;
    xv_pkg::vram_addr_t  rd_addr;   // address of the prefetched word
    xv_pkg::vram_word_t  wr_data;
    xv_pkg::vram_word_t  rd_word;   // prefetched read data
    logic                rd_sent;   // read granted, waiting for rvalid

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= xv_pkg::HS_IDLE;
            wr_addr <= '0;
            rd_addr <= '0;
            rd_sent <= 1'b0;
        end else begin
            case (state)
                xv_pkg::HS_IDLE: begin
                    if (reg_wr) begin
                        case (reg_num)
                            xv_pkg::REG_WR_ADDR: wr_addr <= xv_pkg::vram_addr_t'(reg_wdata);
                            xv_pkg::REG_WR_DATA: state <= xv_pkg::HS_WRITE;
                            xv_pkg::REG_RD_ADDR: begin
                                rd_addr <= xv_pkg::vram_addr_t'(reg_wdata);
                                state   <= xv_pkg::HS_READ;
                            end
                            xv_pkg::REG_RD_DATA: state <= xv_pkg::HS_READ;  // refetch
                            default: state <= xv_pkg::HS_IDLE;
                        endcase
                    end else if (reg_rd && reg_num == xv_pkg::REG_RD_DATA) begin
                        rd_addr <= rd_addr + 1'b1;  // word consumed, fetch next
                        state   <= xv_pkg::HS_READ;
                    end
                end
                xv_pkg::HS_WRITE: begin
                    if (req.gnt) begin
                        wr_addr <= wr_addr + 1'b1;
                        state   <= xv_pkg::HS_IDLE;
                    end
                end
                xv_pkg::HS_READ: begin
                    if (req.rvalid) begin
                        rd_sent <= 1'b0;
                        state   <= xv_pkg::HS_IDLE;
                    end else if (req.gnt) begin
                        rd_sent <= 1'b1;
                    end
                end
                default: state <= xv_pkg::HS_IDLE;
            endcase
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (state == xv_pkg::HS_IDLE && reg_wr && reg_num == xv_pkg::REG_WR_DATA) begin
            wr_data <= reg_wdata;
        end
        if (state == xv_pkg::HS_READ && req.rvalid) begin
            rd_word <= req.rdata;
        end
    end

    assign req.req   = (state == xv_pkg::HS_WRITE) || (state == xv_pkg::HS_READ && !rd_sent);
    assign req.wr_en = (state == xv_pkg::HS_WRITE);
    assign req.addr  = (state == xv_pkg::HS_WRITE) ? wr_addr : rd_addr;
    assign req.wdata = wr_data;

    assign busy = (state != xv_pkg::HS_IDLE);

    always_comb begin
        case (reg_num)
            xv_pkg::REG_WR_ADDR: reg_rdata = xv_pkg::vram_word_t'(wr_addr);
            xv_pkg::REG_RD_ADDR: reg_rdata = xv_pkg::vram_word_t'(rd_addr);
            default:             reg_rdata = rd_word;   // 1 and 3
        endcase
    end

endmodule

// File: vram_arbiter.sv
/*
 * Fixed-priority arbiter for the single VRAM port.
 * The scanner wins whenever it requests, the host gets idle cycles.
 * Owner and read flag are registered to route rvalid back.
 */

`timescale 1ns/1ps

module vram_arbiter (
    input  logic        clk,
    input  logic        rst,
    mem_req_if.arbiter  scan,
    mem_req_if.arbiter  host,
    vram_if.ctrl        mem
);

    logic rd_q;         // a read was performed last cycle
    logic own_scan_q;   // ... and it belonged to the scanner

    // combinational grant
    assign scan.gnt = scan.req;
    assign host.gnt = host.req && !scan.req;

    always_comb begin
        mem.sel = scan.req || host.req;
        if (scan.req) begin
            mem.wr_en = scan.wr_en;
            mem.addr  = scan.addr;
            mem.wdata = scan.wdata;
        end else begin
            mem.wr_en = host.wr_en;
            mem.addr  = host.addr;
            mem.wdata = host.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q       <= 1'b0;
            own_scan_q <= 1'b0;
        end else begin
            rd_q       <= mem.sel && !mem.wr_en;
            own_scan_q <= scan.req;
        end
    end

    // both sides see the data, only the owner sees rvalid
    assign scan.rdata  = mem.rdata;
    assign host.rdata  = mem.rdata;
    assign scan.rvalid = rd_q && own_scan_q;
    assign host.rvalid = rd_q && !own_scan_q;

endmodule

// File: vram.sv
/*
 * Banked VRAM, 64K words as four 16K-word banks.
 * The top address bits pick the bank; the bank of the last access
 * is registered and steers the read mux in the following cycle.
 */

`timescale 1ns/1ps

`include "xv_cfg.svh"

module vram (
    input  logic    clk,
    vram_if.mem     mem
);

    localparam int ADDR_W = $bits(xv_pkg::vram_addr_t);
    localparam int BANK_W = $bits(xv_pkg::bank_t);

    xv_pkg::bank_t      acc_bank;                   // bank of this cycle's access
    xv_pkg::bank_t      rd_bank;                    // bank of the previous access
    xv_pkg::vram_word_t bank_rdata [`XV_BANKS];

    assign acc_bank = mem.addr[ADDR_W-1 -: BANK_W];

    for (genvar b = 0; b < `XV_BANKS; b++) begin : g_bank
        vram_bank bank_i (
            .clk   (clk),
            .sel   (mem.sel && (acc_bank == xv_pkg::bank_t'(b))),
            .wr_en (mem.wr_en),
            .addr  (mem.addr[`XV_BANK_AW-1:0]),
            .wdata (mem.wdata),
            .rdata (bank_rdata[b])
        );
    end

    // remember which bank answers next cycle
    always_ff @(posedge clk) begin
        if (mem.sel) begin
            rd_bank <= acc_bank;
        end
    end

    assign mem.rdata = bank_rdata[rd_bank];

endmodule

// File: vram_bank.sv
/*
 * One VRAM bank: single-port synchronous RAM with registered read.
 * A selected cycle writes on wr_en and returns the old word next cycle.
 * Content starts as the fill word so unwritten words stand out.
 */

`timescale 1ns/1ps

`include "xv_cfg.svh"

module vram_bank (
    input  logic                    clk,
    input  logic                    sel,
    input  logic                    wr_en,
    input  logic [`XV_BANK_AW-1:0]  addr,
    input  xv_pkg::vram_word_t      wdata,
    output xv_pkg::vram_word_t      rdata
);

    xv_pkg::vram_word_t mem_array [2**`XV_BANK_AW];

    initial begin
        for (int i = 0; i < 2**`XV_BANK_AW; i++) begin
            mem_array[i] = `XV_FILL_WORD;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr_en) begin
                mem_array[addr] <= wdata;
            end
            rdata <= mem_array[addr];   // read-before-write
        end
    end

endmodule

// File: xv_ifs.sv
/*
 * Internal buses of the video memory subsystem.
 * mem_req_if joins one requester to the arbiter, one instance per requester.
 * vram_if joins the arbiter to the banked VRAM.
 */

`timescale 1ns/1ps

interface mem_req_if;
    logic                   req;    // held until gnt
    logic                   wr_en;
    xv_pkg::vram_addr_t     addr;
    xv_pkg::vram_word_t     wdata;
    logic                   gnt;    // same cycle as req
    xv_pkg::vram_word_t     rdata;
    logic                   rvalid; // one cycle after a granted read

    modport requester (
        output req, wr_en, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, wr_en, addr, wdata,
        output gnt, rdata, rvalid
    );
endinterface

interface vram_if;
    logic                   sel;
    logic                   wr_en;
    xv_pkg::vram_addr_t     addr;
    xv_pkg::vram_word_t     wdata;
    xv_pkg::vram_word_t     rdata;  // valid the cycle after sel

    modport ctrl (
        output sel, wr_en, addr, wdata,
        input  rdata
    );

    modport mem (
        input  sel, wr_en, addr, wdata,
        output rdata
    );
endinterface

// File: xv_pkg.sv
/*
 * Shared types for the video memory subsystem.
 * Modules refer to these by scoped names (xv_pkg::name).
 */

`include "xv_cfg.svh"

package xv_pkg;

    typedef logic [$clog2(`XV_BANKS)-1:0] bank_t;                   // bank number
    typedef logic [$clog2(`XV_BANKS)+`XV_BANK_AW-1:0] vram_addr_t;  // 16-bit word address
    typedef logic [15:0] vram_word_t;                               // one VRAM word

    // host visible registers
    typedef enum logic [1:0] {
        REG_WR_ADDR = 2'd0,
        REG_WR_DATA = 2'd1,
        REG_RD_ADDR = 2'd2,
        REG_RD_DATA = 2'd3
    } reg_num_t;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WRITE,
        HS_READ
    } host_state_t;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_FETCH,
        SC_DRAIN
    } scan_state_t;

endpackage

// File: xv_cfg.svh
/*
 * Build-time sizes for the video memory subsystem.
 * Included by the package and by the VRAM modules.
 * The total word count is banks times 2**bank address width.
 */

`ifndef XV_CFG_SVH
`define XV_CFG_SVH

// number of VRAM banks, decoded from the top address bits
`define XV_BANKS 4

// word address width inside one bank (16K words)
`define XV_BANK_AW 14

// power-up content, marks locations never written
`define XV_FILL_WORD 16'hdead

`endif
